//--- sim.f
+incdir+.
eeprom_pkg.sv
i2c_bit_if.sv
i2c_byte_engine.sv
eeprom_sequencer.sv
eeprom_wr.sv
eeprom_model.sv
eeprom_wr_properties.sv
tb_eeprom_wr.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) eeprom_consts.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_eeprom_wr.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module tb_eeprom_wr;

    localparam int ACK_TIMEOUT = 5000;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic                  disable_ack;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  ack;
    logic                  busy;
    logic                  nack;
    logic                  scl;
    logic                  dut_oe;
    logic                  mem_oe;
    wire                   sda;

    int                    errors;
    int                    errs_before;
    int                    tests_run;
    int                    tests_failed;
    integer                seed;
    logic [`EE_DATA_W-1:0] sb [0:(1 << `EE_ADDR_W) - 1];
    logic [`EE_ADDR_W-1:0] addrs [0:19];

    assign sda = ~(dut_oe | mem_oe);  // wired AND of both pull-downs

    eeprom_wr u_dut (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .sda_in (sda),
        .rdata  (rdata),
        .ack    (ack),
        .busy   (busy),
        .nack   (nack),
        .scl    (scl),
        .sda_oe (dut_oe)
    );

    eeprom_model u_mem (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda),
        .disable_ack (disable_ack),
        .sda_oe      (mem_oe)
    );

    always #4 CLK = ~CLK;

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (exp == act)
        else
        begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic strobe(input logic do_wr, input logic do_rd,
                          input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr = do_wr;
        rd = do_rd;
        addr = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        while (!ack && n < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!ack)
        begin
            $display("no ack within %0d cycles", ACK_TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic write_byte(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d,
                              input logic exp_nack);
        strobe(1'b1, 1'b0, a, d);
        wait_ack();
        expect_equal("nack", 32'(exp_nack), 32'(nack));
    endtask

    task automatic read_byte(input logic [`EE_ADDR_W-1:0] a, output logic [7:0] d);
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_ack();
        expect_equal("nack", 32'd0, 32'(nack));
        d = rdata;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errs_before)
            $display("%-28s pass", name);
        else
        begin
            $display("%-28s FAIL", name);
            tests_failed++;
        end
        errs_before = errors;
    endtask

    initial
    begin
        logic [7:0]            v;
        logic [7:0]            v0;
        logic [`EE_ADDR_W-1:0] a;
        logic [`EE_ADDR_W-1:0] t;
        int                    j;
        int                    extra;

        seed = 32'h3847;
        CLK = 1'b0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        disable_ack = 1'b0;
        errors = 0;
        errs_before = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        expect_equal("ack", 32'd0, 32'(ack));
        expect_equal("busy", 32'd0, 32'(busy));
        expect_equal("nack", 32'd0, 32'(nack));
        expect_equal("sda_oe", 32'd0, 32'(dut_oe));
        expect_equal("scl", 32'd1, 32'(scl));
        end_test("reset values");

        write_byte(11'h123, 8'h5a, 1'b0);
        read_byte(11'h123, v);
        expect_equal("rdata", 32'h5a, 32'(v));
        end_test("write then read");

        for (int i = 0; i < 20; i++)
        begin
            a = `EE_ADDR_W'($random(seed));
            v = 8'($random(seed));
            write_byte(a, v, 1'b0);
            sb[a] = v;
            addrs[i] = a;
        end
        for (int i = 19; i > 0; i--)
        begin
            j = int'({$random(seed)} % (i + 1));
            t = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = t;
        end
        for (int i = 0; i < 20; i++)
        begin
            read_byte(addrs[i], v);
            expect_equal("rdata", 32'(sb[addrs[i]]), 32'(v));
        end
        end_test("random writes and reads");

        read_byte(11'h6f1, v0);
        @(negedge CLK);
        disable_ack = 1'b1;
        write_byte(11'h6f1, ~v0, 1'b1);
        @(negedge CLK);
        disable_ack = 1'b0;
        read_byte(11'h6f1, v);
        expect_equal("rdata", 32'(v0), 32'(v));
        end_test("missing device ack");

        strobe(1'b1, 1'b0, 11'h2c4, 8'h3c);
        expect_equal("busy", 32'd1, 32'(busy));
        strobe(1'b0, 1'b1, 11'h011, 8'h00);
        strobe(1'b1, 1'b0, 11'h022, 8'hff);
        wait_ack();
        extra = 0;
        repeat (300)
        begin
            @(negedge CLK);
            if (ack)
                extra++;
        end
        expect_equal("extra ack count", 32'd0, 32'(extra));
        end_test("strobes while busy");

        strobe(1'b1, 1'b1, 11'h7a5, 8'hc3);
        wait_ack();
        read_byte(11'h7a5, v);
        expect_equal("rdata", 32'hc3, 32'(v));
        end_test("write wins over read");

        if (u_dut.u_props.fail_cnt != 0)
        begin
            $display("%0d bus assertion failures", u_dut.u_props.fail_cnt);
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- eeprom_wr_properties.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_wr_properties (
    input logic                   CLK,
    input logic                   RESET,
    input logic                   ack,
    input logic                   busy,
    input logic                   scl,
    input logic                   sda_oe,
    input eeprom_pkg::seq_state_e state
);
    import eeprom_pkg::*;

    int unsigned fail_cnt = 0;

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
    else
    begin
        $error("ack longer than one cycle");
        fail_cnt++;
    end

    idle_after_ack: assert property (@(posedge CLK) disable iff (RESET) ack |=> !busy)
    else
    begin
        $error("busy still high after ack");
        fail_cnt++;
    end

    // SDA may only move under a high SCL for start and stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) && scl |-> $past(state) inside {st_wr_start, st_rd_start, st_stop})
    else
    begin
        $error("SDA moved while SCL high");
        fail_cnt++;
    end

    scl_idle_high: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl)
    else
    begin
        $error("SCL low while idle");
        fail_cnt++;
    end

    scl_low_half: assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) |-> !scl [* `EE_SCL_HALF])
    else
    begin
        $error("SCL low half too short");
        fail_cnt++;
    end

endmodule

bind eeprom_wr eeprom_wr_properties u_props (
    .CLK    (CLK),
    .RESET  (RESET),
    .ack    (ack),
    .busy   (busy),
    .scl    (scl),
    .sda_oe (sda_oe),
    .state  (u_seq.state)
);

//--- eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,          // resolved line level
    input  logic disable_ack,  // leave every ack slot released
    output logic sda_oe        // high pulls SDA low
);
    import eeprom_pkg::*;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W) - 1];
    logic                  scl_q;
    logic                  sda_q;
    logic                  active;
    logic                  tx;        // model drives data
    logic                  rd_next;
    logic [3:0]            cnt;       // bits seen in this byte, 9 after the ack clock
    logic [1:0]            idx;       // byte number since start
    logic [7:0]            sh;
    logic [2:0]            block;
    logic [`EE_ADDR_W-1:0] ptr;
    ctrl_byte_u            c;

    always_comb
        c.raw = sh;

    // fill depends on every address bit
    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = 8'(i * 7) ^ 8'(i >> 3);
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            active <= 1'b0;
            tx <= 1'b0;
            rd_next <= 1'b0;
            cnt <= 4'd0;
            idx <= 2'd0;
            sda_oe <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                // start or repeated start
                active <= 1'b1;
                tx <= 1'b0;
                rd_next <= 1'b0;
                cnt <= 4'd0;
                idx <= 2'd0;
                sda_oe <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                active <= 1'b0;  // stop
                sda_oe <= 1'b0;
            end
            else if (active && scl && !scl_q)
            begin
                if (cnt < 4'd8)
                begin
                    if (!tx)
                        sh <= {sh[6:0], sda};
                    cnt <= cnt + 4'd1;
                end
                else
                    cnt <= 4'd9;
            end
            else if (active && !scl && scl_q)
            begin
                if (cnt == 4'd8)
                begin
                    if (tx)
                        sda_oe <= 1'b0;  // master answers
                    else
                    begin
                        sda_oe <= !disable_ack;
                        case (idx)
                            2'd0:
                            begin
                                block <= c.f.block;
                                rd_next <= c.f.rnw;
                                sda_oe <= !disable_ack && (c.f.dev == `EE_DEV_CODE);
                            end
                            2'd1: ptr <= {block, sh};
                            default:
                            begin
                                if (!disable_ack)
                                    mem[ptr] <= sh;
                            end
                        endcase
                        if (idx != 2'd3)
                            idx <= idx + 2'd1;
                    end
                end
                else if (cnt == 4'd9)
                begin
                    cnt <= 4'd0;
                    if (rd_next && !tx)
                    begin
                        tx <= 1'b1;
                        sda_oe <= ~mem[ptr][7];
                    end
                    else
                        sda_oe <= 1'b0;
                end
                else if (tx && cnt != 4'd0)
                    sda_oe <= ~mem[ptr][3'd7 - cnt[2:0]];
            end
        end
    end

endmodule

//--- eeprom_wr.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_wr (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  sda_in,     // resolved line level
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  ack,
    output logic                  busy,
    output logic                  nack,
    output logic                  scl,
    output logic                  sda_oe      // high pulls SDA low
);

    i2c_bit_if u_bus ();

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .busy  (busy),
        .nack  (nack),
        .bus   (u_bus)
    );

    i2c_byte_engine u_eng (
        .CLK    (CLK),
        .RESET  (RESET),
        .sda_in (sda_in),
        .scl    (scl),
        .sda_oe (sda_oe),
        .bus    (u_bus)
    );

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_sequencer (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  ack,
    output logic                  busy,
    output logic                  nack,
    i2c_bit_if.seq bus
);
    import eeprom_pkg::*;

    seq_state_e            state;
    seq_state_e            nxt;
    ctrl_byte_u            ctrl;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic                  rd_q;
    logic                  miss;

    // the device answers on every byte we send
    assign miss = bus.done && bus.ack_in &&
                  (state == st_ctrl_wr || state == st_addr_wr ||
                   state == st_data_wr || state == st_ctrl_rd);

    always_comb
    begin
        case (state)
            st_wr_start: nxt = st_ctrl_wr;
            st_ctrl_wr:  nxt = st_addr_wr;
            st_addr_wr:  nxt = rd_q ? st_rd_start : st_data_wr;
            st_data_wr:  nxt = st_stop;
            st_rd_start: nxt = st_ctrl_rd;
            st_ctrl_rd:  nxt = st_data_rd;
            st_data_rd:  nxt = st_stop;
            st_stop:     nxt = st_done;
            default:     nxt = st_idle;
        endcase
        if (miss)
            nxt = st_stop;  // give up, release the bus
    end

    always_comb
    begin
        case (state)
            st_wr_start, st_rd_start: bus.cmd = cmd_start;
            st_data_rd:               bus.cmd = cmd_read_nack;
            st_stop:                  bus.cmd = cmd_stop;
            default:                  bus.cmd = cmd_write;
        endcase
    end

    always_comb
    begin
        ctrl.f.dev = `EE_DEV_CODE;
        ctrl.f.block = addr_q[`EE_ADDR_W-1:8];
        ctrl.f.rnw = (state == st_ctrl_rd);
        case (state)
            st_addr_wr: bus.tx_byte = addr_q[7:0];
            st_data_wr: bus.tx_byte = wdata_q;
            default:    bus.tx_byte = ctrl.raw;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= st_idle;
            bus.go <= 1'b0;
            ack <= 1'b0;
            busy <= 1'b0;
            nack <= 1'b0;
        end
        else
        begin
            bus.go <= 1'b0;
            ack <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (wr || rd)
                    begin
                        state <= st_wr_start;  // reads also start with a dummy write
                        bus.go <= 1'b1;
                        busy <= 1'b1;
                        nack <= 1'b0;
                    end
                end
                st_done:
                begin
                    ack <= 1'b1;
                    busy <= 1'b0;
                    state <= st_idle;
                end
                default:
                begin
                    if (bus.done)
                    begin
                        state <= nxt;
                        bus.go <= (nxt != st_done);
                        if (miss)
                            nack <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == st_idle && (wr || rd))
        begin
            addr_q <= addr;
            wdata_q <= wdata;
            rd_q <= !wr;  // write wins
        end
        if (state == st_data_rd && bus.done)
            rdata <= bus.rx_byte;
    end

endmodule

//--- i2c_byte_engine.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module i2c_byte_engine (
    input  logic CLK,
    input  logic RESET,
    input  logic sda_in,
    output logic scl,
    output logic sda_oe,
    i2c_bit_if.eng bus
);
    import eeprom_pkg::*;

    localparam int HALF = `EE_SCL_HALF;
    localparam int PW = (HALF > 1) ? $clog2(HALF) : 1;
    localparam logic [PW-1:0] PH_LAST = PW'(HALF - 1);
    localparam logic [PW-1:0] PH_MID = PW'((HALF - 1) / 2);

    logic                  active;
    logic                  high_half;
    logic [PW-1:0]         ph_cnt;
    logic [3:0]            bit_cnt;   // 0..7 data, 8 is the ack slot
    logic [`EE_DATA_W-1:0] shreg;
    logic                  is_byte;
    logic                  last_period;

    assign is_byte = (bus.cmd == cmd_write) || (bus.cmd == cmd_read_ack) ||
                     (bus.cmd == cmd_read_nack);
    assign last_period = !is_byte || (bit_cnt == 4'd8);
    assign bus.rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            high_half <= 1'b0;
            ph_cnt <= '0;
            bit_cnt <= '0;
            scl <= 1'b1;
            sda_oe <= 1'b0;
            bus.done <= 1'b0;
            bus.ack_in <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (!active)
            begin
                if (bus.go)
                begin
                    active <= 1'b1;
                    high_half <= 1'b0;
                    ph_cnt <= '0;
                    bit_cnt <= '0;
                    scl <= 1'b0;   // every command opens with a low half
                    shreg <= bus.tx_byte;   // shifts out msb first
                end
            end
            else
            begin
                // data only moves in the middle of the low half
                if (!high_half && ph_cnt == PH_MID)
                begin
                    case (bus.cmd)
                        cmd_start:    sda_oe <= 1'b0;
                        cmd_stop:     sda_oe <= 1'b1;
                        cmd_write:    sda_oe <= (bit_cnt == 4'd8) ? 1'b0 : ~shreg[7];
                        cmd_read_ack: sda_oe <= (bit_cnt == 4'd8);
                        default:      sda_oe <= 1'b0;
                    endcase
                end

                if (ph_cnt != PH_LAST)
                    ph_cnt <= ph_cnt + 1'b1;
                else
                begin
                    ph_cnt <= '0;
                    if (!high_half)
                    begin
                        high_half <= 1'b1;
                        scl <= 1'b1;
                        if (is_byte)
                        begin
                            if (bit_cnt == 4'd8)
                                bus.ack_in <= sda_in;
                            else
                                shreg <= {shreg[`EE_DATA_W-2:0], sda_in};
                        end
                    end
                    else if (last_period)
                    begin
                        active <= 1'b0;
                        bus.done <= 1'b1;
                        case (bus.cmd)
                            cmd_start: sda_oe <= 1'b1;  // SDA falls, SCL high
                            cmd_stop:  sda_oe <= 1'b0;  // SDA rises, SCL high
                            default:   scl <= 1'b0;     // park low between bytes
                        endcase
                    end
                    else
                    begin
                        high_half <= 1'b0;
                        scl <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
        end
    end

endmodule

//--- i2c_bit_if.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

interface i2c_bit_if;
    import eeprom_pkg::*;

    logic                  go;       // one cycle, engine idle only
    i2c_cmd_e              cmd;
    logic [`EE_DATA_W-1:0] tx_byte;
    logic                  done;
    logic [`EE_DATA_W-1:0] rx_byte;
    logic                  ack_in;   // high means no acknowledge

    modport seq (
        output go, cmd, tx_byte,
        input  done, rx_byte, ack_in
    );

    modport eng (
        input  go, cmd, tx_byte,
        output done, rx_byte, ack_in
    );

endinterface

//--- eeprom_pkg.sv
package eeprom_pkg;

    // commands from sequencer to byte engine
    typedef enum logic [2:0] {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read_ack,
        cmd_read_nack
    } i2c_cmd_e;

    typedef enum logic [3:0] {
        st_idle,
        st_wr_start,
        st_ctrl_wr,
        st_addr_wr,
        st_data_wr,
        st_rd_start,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_done
    } seq_state_e;

    // first byte after start, device code + block + r/w
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev;
            logic [2:0] block;
            logic       rnw;
        } f;
    } ctrl_byte_u;

endpackage

//--- eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// CLK cycles per half SCL period
`define EE_SCL_HALF 2

// 24C16 device type identifier
`define EE_DEV_CODE 4'b1010

`define EE_ADDR_W 11
`define EE_DATA_W 8

`endif
